//--- decode_stage.f
common/decode_pkg.sv
common/decoded_if.sv
hdl/instr_decoder.sv
hdl/operand_select.sv
hdl/decode_control.sv
hdl/dispatch_latch.sv
hdl/decode_stage.sv
sim/decode_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the decode stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f decode_stage.f --top-module decode_stage_tb \
  -Mdir obj_dir -o decode_stage_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/decode_stage_sim)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation passed"; then
  exit 0
fi
echo "pass line missing from simulation output"
exit 1

//--- sim/decode_stage_tb.sv
// randomized testbench for the decode stage, compares dispatch, stall, flush and
// fence behaviour against a reference model of the RV32I decode rules
module decode_stage_tb import decode_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_tests = 3000;
  localparam int timeout_cycles = num_tests + 10 + 200;

  logic       CLK;
  logic       nRST;
  word_t      instr;
  word_t      pc;
  word_t      rs1_data;
  word_t      rs2_data;
  logic       stall_ex;
  logic       flush;
  logic       iflush_done;
  logic       dflush_done;
  reg_addr_t  rs1;
  reg_addr_t  rs2;
  logic       fence_flush;
  logic       fence_busy;
  logic       arith_ena;
  logic       ls_ena;
  logic       is_load;
  logic       is_store;
  logic       wen;
  logic       jump;
  logic       illegal;
  alu_op_t    alu_op;
  load_type_t load_type;
  reg_addr_t  rd;
  word_t      ex_pc;
  word_t      port_a;
  word_t      port_b;
  word_t      store_data;
  word_t      reg_file_wdata;
  word_t      j_base;
  word_t      j_offset;

  // every dispatched output, for the hold check while stalled
  logic [242:0] dispatch_bus;
  logic [242:0] snapshot;

  logic [31:0] rng_state = 32'he5c7eafc;

  // expected latch contents
  logic       e_arith, e_ls, e_load, e_store, e_wen, e_jump, e_illegal;
  alu_op_t    e_alu;
  load_type_t e_lt;
  reg_addr_t  e_rd;
  word_t      e_pc, e_a, e_b, e_sd, e_wd, e_jb, e_jo;
  // which fields the decode rules define for the current entry
  logic       c_rd, c_alu, c_ops, c_wdata, c_jt, c_lt;
  logic       m_fence_q;
  logic [1:0] m_flushed;
  logic       held;

  decode_stage dut_i (.*);

  assign dispatch_bus = {arith_ena, ls_ena, is_load, is_store, wen, jump, illegal, alu_op,
                         load_type, rd, ex_pc, port_a, port_b, store_data, reg_file_wdata,
                         j_base, j_offset};

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  initial begin
    #(timeout_cycles * 8);
    $display("run timed out before all %0d tests finished", num_tests);
    $display("Simulation failed");
    $fatal(1, "watchdog expired");
  end

  function automatic word_t next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state ^ (rng_state >> 16);
  endfunction

  // mostly legal opcodes, a few branch, system and random ones
  function automatic word_t make_instr(input logic prefer_fence);
    word_t      body;
    word_t      r;
    logic [6:0] opc;
    body = next_rand();
    r = next_rand();
    case (r[31:28])
      4'd0, 4'd1:   opc = OP;
      4'd2, 4'd3:   opc = OP_IMM;
      4'd4:         opc = LUI;
      4'd5:         opc = AUIPC;
      4'd6:         opc = JAL;
      4'd7:         opc = JALR;
      4'd8, 4'd9:   opc = LOAD;
      4'd10, 4'd11: opc = STORE;
      4'd12:        opc = MISC_MEM;
      4'd13:        opc = 7'b1100011;
      4'd14:        opc = 7'b1110011;
      default:      opc = body[6:0];
    endcase
    // bias toward runs of fences
    if (prefer_fence && r[0]) begin
      opc = MISC_MEM;
    end
    return {body[31:7], opc};
  endfunction

  function automatic alu_op_t expected_alu(input logic [2:0] f3, input logic bit30,
                                           input logic reg_op);
    case (f3)
      3'd0:    return (reg_op && bit30) ? SUB : ADD;
      3'd1:    return SLL;
      3'd2:    return SLT;
      3'd3:    return SLTU;
      3'd4:    return XOR;
      3'd5:    return bit30 ? SRA : SRL;
      3'd6:    return OR;
      default: return AND;
    endcase
  endfunction

  task automatic set_bubble();
    {e_arith, e_ls, e_load, e_store, e_wen, e_jump, e_illegal} = '0;
    e_alu = ADD;
    e_lt = '0;
    e_rd = '0;
    {e_pc, e_a, e_b, e_sd, e_wd, e_jb, e_jo} = '0;
    {c_rd, c_alu, c_jt, c_lt} = '0;
    c_ops = 1'b1;
    c_wdata = 1'b1;
  endtask

  task automatic capture_model(input word_t ins, input word_t pc_v, input word_t a,
                               input word_t b);
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_j;
    word_t      imm_u;
    logic [2:0] f3;
    logic [6:0] opc;
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    imm_u = {ins[31:12], 12'h000};
    f3 = ins[14:12];
    opc = ins[6:0];
    set_bubble();
    {c_ops, c_wdata} = '0;
    c_rd = 1'b1;
    e_rd = ins[11:7];
    e_pc = pc_v;
    case (opc)
      OP, OP_IMM: begin
        {e_arith, e_wen, c_ops, c_alu, c_wdata} = '1;
        e_a = a;
        e_b = (opc == OP) ? b : ((f3 == 3'd1 || f3 == 3'd5) ? {27'd0, ins[24:20]} : imm_i);
        e_alu = expected_alu(f3, ins[30], opc == OP);
      end
      LUI, AUIPC: begin
        {e_arith, e_wen, c_ops, c_alu, c_wdata} = '1;
        e_a = (opc == LUI) ? '0 : pc_v;
        e_b = imm_u;
        e_wd = (opc == LUI) ? imm_u : '0;
      end
      JAL, JALR: begin
        {e_arith, e_wen, e_jump, c_jt, c_wdata} = '1;
        e_wd = pc_v + 32'd4;
        e_jb = (opc == JAL) ? pc_v : a;
        e_jo = (opc == JAL) ? imm_j : imm_i;
      end
      LOAD: begin
        {e_ls, e_load, e_wen, c_ops, c_lt} = '1;
        e_a = a;
        e_b = imm_i;
        e_lt = f3;
      end
      STORE: begin
        {e_ls, e_store, c_ops, c_lt} = '1;
        e_a = imm_s;
        e_b = a;
        e_sd = b;
        e_lt = f3;
      end
      MISC_MEM: set_bubble();
      default: e_illegal = 1'b1;
    endcase
    // x0 is never written
    if (ins[11:7] == 5'd0) begin
      e_wen = 1'b0;
    end
  endtask

  // applies one rising edge to the model, using the inputs of the ending cycle
  task automatic step_model();
    logic fence_now;
    fence_now = (instr[6:0] == MISC_MEM);
    held = stall_ex && !flush;
    if (fence_now && !m_fence_q) begin
      m_flushed = 2'b00;
    end else if (!stall_ex) begin
      m_flushed = m_flushed | {dflush_done, iflush_done};
    end
    if (!stall_ex) begin
      m_fence_q = fence_now;
    end
    if (flush) begin
      set_bubble();
    end else if (!stall_ex) begin
      capture_model(instr, pc, rs1_data, rs2_data);
    end
  endtask

  task automatic drive_inputs();
    word_t r;
    r = next_rand();
    // instr stays put while execute is stalled
    if (!stall_ex) begin
      instr = make_instr(instr[6:0] == MISC_MEM);
      pc = next_rand() & 32'hffff_fffc;
      rs1_data = next_rand();
      rs2_data = next_rand();
    end
    stall_ex = (r[31:30] == 2'b00);
    flush = (r[29:26] == 4'd0);
    iflush_done = (r[25:24] == 2'b00);
    dflush_done = (r[23:22] == 2'b00);
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic got);
    assert (got === exp) else begin
      $display("error %s expected %h got %h", name, exp, got);
      $display("Simulation failed");
      $fatal(1, "check on %s failed", name);
    end
  endtask

  task automatic compare_word(input string name, input word_t exp, input word_t got);
    assert (got === exp) else begin
      $display("error %s expected %h got %h", name, exp, got);
      $display("Simulation failed");
      $fatal(1, "check on %s failed", name);
    end
  endtask

  task automatic verify_dispatch();
    compare_bit("arith_ena", e_arith, arith_ena);
    compare_bit("ls_ena", e_ls, ls_ena);
    compare_bit("wen", e_wen, wen);
    compare_bit("jump", e_jump, jump);
    compare_bit("illegal", e_illegal, illegal);
    compare_word("store_data", e_sd, store_data);
    if (c_rd) begin
      compare_word("rd", 32'(e_rd), 32'(rd));
      compare_word("ex_pc", e_pc, ex_pc);
      compare_bit("is_load", e_load, is_load);
      compare_bit("is_store", e_store, is_store);
    end
    if (c_alu) compare_word("alu_op", 32'(e_alu), 32'(alu_op));
    if (c_ops) begin
      compare_word("port_a", e_a, port_a);
      compare_word("port_b", e_b, port_b);
    end
    if (c_wdata) compare_word("reg_file_wdata", e_wd, reg_file_wdata);
    if (c_jt) begin
      compare_word("j_base", e_jb, j_base);
      compare_word("j_offset", e_jo, j_offset);
    end
    if (c_lt) compare_word("load_type", 32'(e_lt), 32'(load_type));
    compare_bit("fence_busy", !(&m_flushed), fence_busy);
    if (held) begin
      assert (dispatch_bus === snapshot) else begin
        $display("error dispatch_bus expected %h got %h", snapshot, dispatch_bus);
        $display("Simulation failed");
        $fatal(1, "dispatch outputs changed while stalled");
      end
    end
    snapshot = dispatch_bus;
  endtask

  task automatic verify_decode();
    compare_word("rs1", 32'(instr[19:15]), 32'(rs1));
    compare_word("rs2", 32'(instr[24:20]), 32'(rs2));
    compare_bit("fence_flush", (instr[6:0] == MISC_MEM) && !m_fence_q, fence_flush);
  endtask

  initial begin
    nRST = 1'b0;
    instr = 32'h0000_0013;
    pc = '0;
    rs1_data = '0;
    rs2_data = '0;
    stall_ex = 1'b0;
    flush = 1'b0;
    iflush_done = 1'b0;
    dflush_done = 1'b0;
    set_bubble();
    m_fence_q = 1'b0;
    m_flushed = 2'b11;
    held = 1'b0;
    snapshot = '0;

    repeat (10) @(posedge CLK);
    #1;
    verify_dispatch();
    nRST = 1'b1;
    drive_inputs();
    #1;
    verify_decode();

    for (int n = 0; n < num_tests; n++) begin
      @(posedge CLK);
      step_model();
      #1;
      verify_dispatch();
      drive_inputs();
      #1;
      verify_decode();
    end

    $display("Simulation passed");
    $finish;
  end

endmodule

//--- hdl/decode_stage.sv
// decode stage top level, register file and caches connect through plain ports
// decode is combinational, dispatch appears one cycle later from the latch
module decode_stage import decode_pkg::*; (
  input  logic       CLK,
  input  logic       nRST,
  input  word_t      instr,
  input  word_t      pc,
  input  word_t      rs1_data,
  input  word_t      rs2_data,
  input  logic       stall_ex,
  input  logic       flush,
  input  logic       iflush_done,
  input  logic       dflush_done,
  output reg_addr_t  rs1,
  output reg_addr_t  rs2,
  output logic       fence_flush,
  output logic       fence_busy,
  output logic       arith_ena,
  output logic       ls_ena,
  output logic       is_load,
  output logic       is_store,
  output logic       wen,
  output logic       jump,
  output logic       illegal,
  output alu_op_t    alu_op,
  output load_type_t load_type,
  output reg_addr_t  rd,
  output word_t      ex_pc,
  output word_t      port_a,
  output word_t      port_b,
  output word_t      store_data,
  output word_t      reg_file_wdata,
  output word_t      j_base,
  output word_t      j_offset
);

  decoded_if dec_if ();

  word_t sel_port_a;
  word_t sel_port_b;
  word_t sel_wdata;
  word_t sel_j_base;
  word_t sel_j_offset;
  logic  latch_load;
  logic  latch_clear;

  instr_decoder decoder_i (
    .instr (instr),
    .rs1   (rs1),
    .rs2   (rs2),
    .d     (dec_if.decoder)
  );

  operand_select operand_select_i (
    .instr          (instr),
    .pc             (pc),
    .rs1_data       (rs1_data),
    .rs2_data       (rs2_data),
    .d              (dec_if.sink),
    .port_a         (sel_port_a),
    .port_b         (sel_port_b),
    .reg_file_wdata (sel_wdata),
    .j_base         (sel_j_base),
    .j_offset       (sel_j_offset)
  );

  decode_control control_i (
    .CLK         (CLK),
    .nRST        (nRST),
    .stall_ex    (stall_ex),
    .flush       (flush),
    .iflush_done (iflush_done),
    .dflush_done (dflush_done),
    .d           (dec_if.ctrl),
    .fence_flush (fence_flush),
    .fence_busy  (fence_busy),
    .latch_load  (latch_load),
    .latch_clear (latch_clear)
  );

  dispatch_latch latch_i (
    .CLK            (CLK),
    .nRST           (nRST),
    .latch_load     (latch_load),
    .latch_clear    (latch_clear),
    .d              (dec_if.sink),
    .pc             (pc),
    .port_a_in      (sel_port_a),
    .port_b_in      (sel_port_b),
    .wdata_in       (sel_wdata),
    .j_base_in      (sel_j_base),
    .j_offset_in    (sel_j_offset),
    .rs2_data       (rs2_data),
    .arith_ena      (arith_ena),
    .ls_ena         (ls_ena),
    .is_load        (is_load),
    .is_store       (is_store),
    .wen            (wen),
    .jump           (jump),
    .illegal        (illegal),
    .alu_op         (alu_op),
    .load_type      (load_type),
    .rd             (rd),
    .ex_pc          (ex_pc),
    .port_a         (port_a),
    .port_b         (port_b),
    .store_data     (store_data),
    .reg_file_wdata (reg_file_wdata),
    .j_base         (j_base),
    .j_offset       (j_offset)
  );

endmodule

//--- hdl/dispatch_latch.sv
// decode to execute pipeline register, holds while execute stalls and
// loads a bubble on a flush or a fence
module dispatch_latch import decode_pkg::*; (
  input  logic       CLK,
  input  logic       nRST,
  input  logic       latch_load,
  input  logic       latch_clear,
  decoded_if.sink    d,
  input  word_t      pc,
  input  word_t      port_a_in,
  input  word_t      port_b_in,
  input  word_t      wdata_in,
  input  word_t      j_base_in,
  input  word_t      j_offset_in,
  input  word_t      rs2_data,
  output logic       arith_ena,
  output logic       ls_ena,
  output logic       is_load,
  output logic       is_store,
  output logic       wen,
  output logic       jump,
  output logic       illegal,
  output alu_op_t    alu_op,
  output load_type_t load_type,
  output reg_addr_t  rd,
  output word_t      ex_pc,
  output word_t      port_a,
  output word_t      port_b,
  output word_t      store_data,
  output word_t      reg_file_wdata,
  output word_t      j_base,
  output word_t      j_offset
);

  logic bubble;
  logic update;

  // clear wins over load, a fence dispatches nothing
  assign bubble = latch_clear || d.fence;
  assign update = latch_clear || latch_load;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      arith_ena      <= 1'b0;
      ls_ena         <= 1'b0;
      is_load        <= 1'b0;
      is_store       <= 1'b0;
      wen            <= 1'b0;
      jump           <= 1'b0;
      illegal        <= 1'b0;
      alu_op         <= ADD;
      load_type      <= '0;
      rd             <= '0;
      ex_pc          <= '0;
      port_a         <= '0;
      port_b         <= '0;
      store_data     <= '0;
      reg_file_wdata <= '0;
      j_base         <= '0;
      j_offset       <= '0;
    end else if (update && bubble) begin
      arith_ena      <= 1'b0;
      ls_ena         <= 1'b0;
      is_load        <= 1'b0;
      is_store       <= 1'b0;
      wen            <= 1'b0;
      jump           <= 1'b0;
      illegal        <= 1'b0;
      alu_op         <= ADD;
      load_type      <= '0;
      rd             <= '0;
      ex_pc          <= '0;
      port_a         <= '0;
      port_b         <= '0;
      store_data     <= '0;
      reg_file_wdata <= '0;
      j_base         <= '0;
      j_offset       <= '0;
    end else if (update) begin
      arith_ena      <= d.arith_ena;
      ls_ena         <= d.ls_ena;
      is_load        <= d.is_load;
      is_store       <= d.is_store;
      wen            <= d.wen;
      jump           <= d.jump;
      illegal        <= d.illegal;
      alu_op         <= d.alu_op;
      load_type      <= d.load_type;
      rd             <= d.rd;
      ex_pc          <= pc;
      port_a         <= port_a_in;
      port_b         <= port_b_in;
      store_data     <= d.is_store ? rs2_data : '0;
      reg_file_wdata <= wdata_in;
      j_base         <= j_base_in;
      j_offset       <= j_offset_in;
    end
  end

  assert property (@(posedge CLK) disable iff (!nRST) !(arith_ena && ls_ena));

endmodule

//--- hdl/decode_control.sv
// fence.i flush pulse to both caches, flush completion tracking and the
// load and clear enables of the dispatch latch
module decode_control import decode_pkg::*; (
  input  logic CLK,
  input  logic nRST,
  input  logic stall_ex,
  input  logic flush,
  input  logic iflush_done,
  input  logic dflush_done,
  decoded_if.ctrl d,
  output logic fence_flush,
  output logic fence_busy,
  output logic latch_load,
  output logic latch_clear
);

  logic       fence_q;
  // bit 0 tracks the icache, bit 1 the dcache
  logic [1:0] flushed;
  logic [1:0] done_in;

  // rising edge of fence decode, a run of fences flushes once
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      fence_q <= 1'b0;
    end else if (!stall_ex) begin
      fence_q <= d.fence;
    end
  end

  assign fence_flush = (d.opcode == MISC_MEM) && !fence_q;

  assign done_in = {dflush_done, iflush_done};

  // each cache is idle until a flush starts, then sticky once it reports done
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      flushed <= 2'b11;
    end else if (fence_flush) begin
      flushed <= 2'b00;
    end else if (!stall_ex) begin
      flushed <= flushed | done_in;
    end
  end

  assign fence_busy = !(&flushed);

  assign latch_load  = !stall_ex;
  assign latch_clear = flush;

  // the edge register must retire the pulse once execute accepts it
  assert property (@(posedge CLK) disable iff (!nRST)
    (fence_flush && !stall_ex) |=> !fence_flush);

endmodule

//--- hdl/operand_select.sv
// immediate generation and source muxing for the two functional unit ports,
// the write-back value and the jump target base and offset
module operand_select import decode_pkg::*; (
  input  word_t instr,
  input  word_t pc,
  input  word_t rs1_data,
  input  word_t rs2_data,
  decoded_if.sink d,
  output word_t port_a,
  output word_t port_b,
  output word_t reg_file_wdata,
  output word_t j_base,
  output word_t j_offset
);

  word_t imm_i;
  word_t imm_s;
  word_t imm_j;
  word_t imm_u;
  word_t shamt;
  word_t pc4;

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign shamt = {{(word_w - 5){1'b0}}, instr[24:20]};
  assign pc4   = pc + word_t'(4);

  always_comb begin
    case (d.src_a)
      SRC_A_RS1:   port_a = rs1_data;
      SRC_A_IMM_S: port_a = imm_s;
      SRC_A_PC:    port_a = pc;
      default:     port_a = '0;
    endcase

    case (d.src_b)
      SRC_B_RS1:            port_b = rs1_data;
      SRC_B_RS2:            port_b = rs2_data;
      SRC_B_IMM_I_OR_SHAMT: port_b = d.imm_shamt ? shamt : imm_i;
      default:              port_b = imm_u;
    endcase

    case (d.w_src)
      WSRC_PC4:   reg_file_wdata = pc4;
      WSRC_IMM_U: reg_file_wdata = imm_u;
      default:    reg_file_wdata = '0;
    endcase
  end

  // jal is pc relative, jalr is register relative
  assign j_base   = d.j_sel ? pc : rs1_data;
  assign j_offset = d.j_sel ? imm_j : imm_i;

endmodule

//--- hdl/instr_decoder.sv
// combinational RV32I decoder, maps one instruction to unit selection,
// operand selectors, enables and register addresses
module instr_decoder import decode_pkg::*; (
  input  word_t     instr,
  output reg_addr_t rs1,
  output reg_addr_t rs2,
  decoded_if.decoder d
);

  logic [2:0] funct3;
  logic       alt;
  logic       unit_en;
  logic       wen_req;

  // immediate forms never produce SUB, and SRA only via the shift encoding
  function automatic alu_op_t alu_from_funct(input logic [2:0] f3, input logic alt_bit,
                                             input logic reg_form);
    alu_op_t op;
    case (f3)
      3'b000:  op = (reg_form && alt_bit) ? SUB : ADD;
      3'b001:  op = SLL;
      3'b010:  op = SLT;
      3'b011:  op = SLTU;
      3'b100:  op = XOR;
      3'b101:  op = alt_bit ? SRA : SRL;
      3'b110:  op = OR;
      default: op = AND;
    endcase
    return op;
  endfunction

  assign funct3 = instr[14:12];
  assign alt    = instr[30];

  assign rs1         = instr[19:15];
  assign rs2         = instr[24:20];
  assign d.rd        = instr[11:7];
  assign d.load_type = funct3;
  assign d.opcode    = opcode_t'(instr[6:0]);

  always_comb begin
    d.fu_type   = FU_ARITH;
    d.alu_op    = ADD;
    d.src_a     = SRC_A_RS1;
    d.src_b     = SRC_B_RS2;
    d.imm_shamt = 1'b0;
    d.w_src     = WSRC_NONE;
    d.is_load   = 1'b0;
    d.is_store  = 1'b0;
    d.jump      = 1'b0;
    d.j_sel     = 1'b0;
    d.fence     = 1'b0;
    d.illegal   = 1'b0;
    unit_en     = 1'b1;
    wen_req     = 1'b1;

    case (d.opcode)
      OP: begin
        d.alu_op = alu_from_funct(funct3, alt, 1'b1);
      end
      OP_IMM: begin
        d.alu_op    = alu_from_funct(funct3, alt, 1'b0);
        d.src_b     = SRC_B_IMM_I_OR_SHAMT;
        d.imm_shamt = (funct3 == 3'b001) || (funct3 == 3'b101);
      end
      LUI: begin
        d.src_a = SRC_A_ZERO;
        d.src_b = SRC_B_IMM_U;
        d.w_src = WSRC_IMM_U;
      end
      AUIPC: begin
        d.src_a = SRC_A_PC;
        d.src_b = SRC_B_IMM_U;
      end
      JAL: begin
        d.jump  = 1'b1;
        d.j_sel = 1'b1;
        d.w_src = WSRC_PC4;
      end
      JALR: begin
        d.jump  = 1'b1;
        d.w_src = WSRC_PC4;
      end
      LOAD: begin
        d.fu_type = FU_LDST;
        d.src_b   = SRC_B_IMM_I_OR_SHAMT;
        d.is_load = 1'b1;
      end
      STORE: begin
        d.fu_type  = FU_LDST;
        d.src_a    = SRC_A_IMM_S;
        d.src_b    = SRC_B_RS1;
        d.is_store = 1'b1;
        wen_req    = 1'b0;
      end
      MISC_MEM: begin
        // fence goes to no unit, execute sees a bubble
        d.fence = 1'b1;
        unit_en = 1'b0;
        wen_req = 1'b0;
      end
      default: begin
        d.illegal = 1'b1;
        unit_en   = 1'b0;
        wen_req   = 1'b0;
      end
    endcase

    d.arith_ena = unit_en && (d.fu_type == FU_ARITH);
    d.ls_ena    = unit_en && (d.fu_type == FU_LDST);
    // x0 is never written
    d.wen       = wen_req && (d.rd != '0);
  end

endmodule

//--- common/decoded_if.sv
// decoded control fields, driven by the instruction decoder and read by
// operand selection, the dispatch latch and the fence control
interface decoded_if import decode_pkg::*; ();

  opcode_t    opcode;
  fu_type_t   fu_type;
  alu_op_t    alu_op;
  src_a_sel_t src_a;
  src_b_sel_t src_b;
  logic       imm_shamt;
  wsrc_t      w_src;
  reg_addr_t  rd;
  logic       wen;
  logic       arith_ena;
  logic       ls_ena;
  logic       is_load;
  logic       is_store;
  load_type_t load_type;
  logic       jump;
  logic       j_sel;
  logic       fence;
  logic       illegal;

  modport decoder (
    output opcode, fu_type, alu_op, src_a, src_b, imm_shamt, w_src, rd, wen,
           arith_ena, ls_ena, is_load, is_store, load_type, jump, j_sel, fence, illegal
  );

  modport sink (
    input alu_op, src_a, src_b, imm_shamt, w_src, rd, wen, arith_ena, ls_ena,
          is_load, is_store, load_type, jump, j_sel, fence, illegal
  );

  modport ctrl (input opcode, fence);

endinterface

//--- common/decode_pkg.sv
// shared widths, word types and decode encodings for the RV32I decode stage
// imported by every module and interface of the stage
package decode_pkg;

  localparam int word_w = 32;
  localparam int reg_addr_w = 5;

  typedef logic [word_w-1:0] word_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  // funct3 of a load or store, passed through to the LSU unchanged
  typedef logic [2:0] load_type_t;

  // major opcodes handled by this stage, anything else is illegal
  typedef enum logic [6:0] {
    OP       = 7'b0110011,
    OP_IMM   = 7'b0010011,
    LUI      = 7'b0110111,
    AUIPC    = 7'b0010111,
    JAL      = 7'b1101111,
    JALR     = 7'b1100111,
    LOAD     = 7'b0000011,
    STORE    = 7'b0100011,
    MISC_MEM = 7'b0001111
  } opcode_t;

  // low 3 bits follow funct3, bit 3 is instr[30] for SUB and SRA
  typedef enum logic [3:0] {
    ADD  = 4'b0000,
    SLL  = 4'b0001,
    SLT  = 4'b0010,
    SLTU = 4'b0011,
    XOR  = 4'b0100,
    SRL  = 4'b0101,
    OR   = 4'b0110,
    AND  = 4'b0111,
    SUB  = 4'b1000,
    SRA  = 4'b1101
  } alu_op_t;

  typedef enum logic {
    FU_ARITH = 1'b0,
    FU_LDST  = 1'b1
  } fu_type_t;

  typedef enum logic [1:0] {
    SRC_A_RS1   = 2'd0,
    SRC_A_IMM_S = 2'd1,
    SRC_A_PC    = 2'd2,
    SRC_A_ZERO  = 2'd3
  } src_a_sel_t;

  typedef enum logic [1:0] {
    SRC_B_RS1            = 2'd0,
    SRC_B_RS2            = 2'd1,
    SRC_B_IMM_I_OR_SHAMT = 2'd2,
    SRC_B_IMM_U          = 2'd3
  } src_b_sel_t;

  typedef enum logic [1:0] {
    WSRC_NONE  = 2'd0,
    WSRC_PC4   = 2'd1,
    WSRC_IMM_U = 2'd2
  } wsrc_t;

endpackage
